/* all.f */
hw/acq_pkg.sv
hw/spi_pkg.sv
hw/spi_bus_if.sv
hw/spi_slave.sv
hw/reg_bank.sv
hw/seq_acq.sv
hw/result_fifo.sv
hw/dmm_top.sv
tests/tb_dmm_top.sv

/* hw/acq_pkg.sv */
/*
  acquisition definitions
  widths, operating modes, sequencer states, sequence entry and result record
*/
package acq_pkg;

  localparam int REG_W        = 32;   // register / data word
  localparam int SEQ_ENTRIES  = 4;    // programmable sequence entries
  localparam int SEQ_N_W      = 3;    // sequence length field
  localparam int AZMUX_W      = 4;    // azero mux select
  localparam int PC_SW_W      = 2;    // precharge switches
  localparam int COUNT_W      = 24;   // precharge / aperture counters
  localparam int SERIAL_W     = 24;   // sample serial in the record
  localparam int RESULT_DEPTH = 4;    // fifo depth, also initial credits
  localparam int LEVEL_W      = 3;    // fifo level 0..depth

  // operating mode, cr bits 2:0
  typedef enum logic [2:0] {
    MODE_DIRECT = 3'd0,     // outputs from the direct register
    MODE_SEQ    = 3'd6      // sequencer with mocked conversion
  } mode_e;

  typedef enum logic [1:0] {
    ST_IDLE        = 2'd0,
    ST_PRECHARGE   = 2'd1,
    ST_APERTURE    = 2'd2,
    ST_WAIT_CREDIT = 2'd3   // aperture done, fifo has no room
  } seq_state_e;

  // one sequence entry, low bits of a seq register
  typedef struct packed {
    logic [PC_SW_W-1:0] pc_sw;    // bits 5:4
    logic [AZMUX_W-1:0] azmux;    // bits 3:0
  } seq_entry_t;

  // result record, one per sample
  typedef struct packed {
    logic [SERIAL_W-1:0] serial;      // samples since trigger rose
    logic [AZMUX_W-1:0]  azmux;
    logic                first;       // sample index 0
    logic [SEQ_N_W-1:0]  sample_idx;
  } result_t;

endpackage

/* hw/dmm_top.sv */
/*
  bench-meter control core
  chip-select decode, spi line muxing, register bank, sequencer, result fifo
  and registered mode select onto the board outputs
*/
`timescale 1ns/10ps

module dmm_top
(
  input  logic       CLK,
  input  logic       rst_i,
  input  logic       SCK,
  input  logic       SDI,
  output logic       SDO,
  input  logic [2:0] spi_cs_vec_i,
  output logic       spi_glb_clk_o,
  output logic       spi_glb_mosi_o,
  output logic       spi_4094_strobe_o,
  output logic       spi_invert_dac_ss_o,
  output logic       spi_iso_cs_o,
  input  logic [3:0] hw_flags_i,
  input  logic       sa_trig_i,
  output logic [3:0] leds_o,
  output logic [7:0] monitor_o,
  output logic [1:0] pc_sw_o,
  output logic [3:0] azmux_o,
  output logic       spi_interrupt_o
);

  logic                          fpga_sel;
  acq_pkg::mode_e                mode;
  logic [acq_pkg::REG_W-1:0]     direct;
  logic [acq_pkg::COUNT_W-1:0]   precharge;
  logic [acq_pkg::COUNT_W-1:0]   aperture;
  logic [acq_pkg::SEQ_N_W-1:0]   seq_n;
  acq_pkg::seq_entry_t [acq_pkg::SEQ_ENTRIES-1:0] seq;
  logic [acq_pkg::LEVEL_W-1:0]   level;
  acq_pkg::result_t              head;
  acq_pkg::result_t              record;
  logic                          pop;
  logic                          push;
  logic                          credit_ret;
  logic                          running;
  logic [3:0]                    sa_leds;
  logic [7:0]                    sa_monitor;
  logic [1:0]                    sa_pc_sw;
  logic [3:0]                    sa_azmux;

  ////////////////////////////////////////
  // chip select decode

  assign fpga_sel            = (spi_cs_vec_i == spi_pkg::CS_FPGA);
  assign spi_glb_clk_o       = fpga_sel ? 1'b1 : SCK;     // park high for fpga access
  assign spi_glb_mosi_o      = fpga_sel ? 1'b1 : SDI;
  assign spi_4094_strobe_o   = (spi_cs_vec_i == spi_pkg::CS_4094);            // active high
  assign spi_invert_dac_ss_o = (spi_cs_vec_i != spi_pkg::CS_INVERT_DAC);      // active low
  assign spi_iso_cs_o        = (spi_cs_vec_i != spi_pkg::CS_MDAC);            // active low

  spi_bus_if u_spi_bus ();

  spi_slave u_spi_slave
  (
    .CLK(CLK), .rst_i(rst_i), .sck_i(SCK), .sdi_i(SDI), .cs_i(fpga_sel),
    .sdo_o(SDO), .bus(u_spi_bus)
  );

  reg_bank u_reg_bank
  (
    .CLK(CLK), .rst_i(rst_i), .bus(u_spi_bus), .hw_flags_i(hw_flags_i),
    .running_i(running), .level_i(level), .head_i(head), .pop_o(pop),
    .mode_o(mode), .direct_o(direct), .precharge_o(precharge),
    .aperture_o(aperture), .seq_n_o(seq_n), .seq_o(seq)
  );

  seq_acq u_seq_acq
  (
    .CLK(CLK), .rst_i(rst_i), .trig_i(sa_trig_i),
    .enable_i(mode == acq_pkg::MODE_SEQ), .precharge_i(precharge),
    .aperture_i(aperture), .seq_n_i(seq_n), .seq_i(seq),
    .credit_ret_i(credit_ret), .push_o(push), .record_o(record),
    .azmux_o(sa_azmux), .pc_sw_o(sa_pc_sw), .running_o(running),
    .leds_o(sa_leds), .monitor_o(sa_monitor)
  );

  result_fifo u_result_fifo
  (
    .CLK(CLK), .rst_i(rst_i), .push_i(push), .record_i(record), .pop_i(pop),
    .head_o(head), .level_o(level), .credit_ret_o(credit_ret)
  );

  ////////////////////////////////////////
  // mode select, registered board outputs

  always_ff @(posedge CLK)
  begin
    if (rst_i)
    begin
      leds_o          <= '0;
      monitor_o       <= '0;
      pc_sw_o         <= '0;
      azmux_o         <= '0;
      spi_interrupt_o <= 1'b0;
    end
    else
    begin
      case (mode)
        acq_pkg::MODE_DIRECT:
        begin
          leds_o          <= direct[3:0];
          monitor_o       <= direct[11:4];
          pc_sw_o         <= direct[13:12];
          azmux_o         <= direct[17:14];
          spi_interrupt_o <= direct[18];
        end
        acq_pkg::MODE_SEQ:
        begin
          leds_o          <= sa_leds;
          monitor_o       <= sa_monitor;
          pc_sw_o         <= sa_pc_sw;
          azmux_o         <= sa_azmux;
          spi_interrupt_o <= (level != '0);   // results waiting
        end
        default:                              // unused modes, all low
        begin
          leds_o          <= '0;
          monitor_o       <= '0;
          pc_sw_o         <= '0;
          azmux_o         <= '0;
          spi_interrupt_o <= 1'b0;
        end
      endcase
    end
  end

endmodule

/* hw/reg_bank.sv */
/*
  control register bank
  writable parameters, status word, result fifo readout with pop
*/
`timescale 1ns/10ps

module reg_bank
(
  input  logic                          CLK,
  input  logic                          rst_i,
  spi_bus_if.bank                       bus,
  input  logic [3:0]                    hw_flags_i,
  input  logic                          running_i,
  input  logic [acq_pkg::LEVEL_W-1:0]   level_i,
  input  acq_pkg::result_t              head_i,
  output logic                          pop_o,
  output acq_pkg::mode_e                mode_o,
  output logic [acq_pkg::REG_W-1:0]     direct_o,
  output logic [acq_pkg::COUNT_W-1:0]   precharge_o,
  output logic [acq_pkg::COUNT_W-1:0]   aperture_o,
  output logic [acq_pkg::SEQ_N_W-1:0]   seq_n_o,
  output acq_pkg::seq_entry_t [acq_pkg::SEQ_ENTRIES-1:0] seq_o
);

  logic [acq_pkg::REG_W-1:0] cr_q;
  logic [acq_pkg::REG_W-1:0] direct_q;
  logic [acq_pkg::REG_W-1:0] precharge_q;
  logic [acq_pkg::REG_W-1:0] aperture_q;
  logic [acq_pkg::REG_W-1:0] seq_n_q;
  logic [acq_pkg::REG_W-1:0] seq_q [acq_pkg::SEQ_ENTRIES];
  logic [acq_pkg::REG_W-1:0] status_w;
  logic [acq_pkg::REG_W-1:0] rd_word;

  ////////////////////////////////////////
  // register writes

  always_ff @(posedge CLK)
  begin
    if (rst_i)
    begin
      cr_q        <= '0;          // direct mode
      direct_q    <= '0;
      precharge_q <= '0;
      aperture_q  <= '0;
      seq_n_q     <= '0;
      seq_q       <= '{default: '0};
    end
    else if (bus.wr)
    begin
      case (bus.addr)
        spi_pkg::REG_CR:        cr_q        <= bus.wdata;
        spi_pkg::REG_DIRECT:    direct_q    <= bus.wdata;
        spi_pkg::REG_PRECHARGE: precharge_q <= bus.wdata;
        spi_pkg::REG_APERTURE:  aperture_q  <= bus.wdata;
        spi_pkg::REG_SEQ_N:     seq_n_q     <= bus.wdata;
        default: ;              // status, result are read only
      endcase
      for (int i = 0; i < acq_pkg::SEQ_ENTRIES; i++)
        if (bus.addr == spi_pkg::reg_addr_e'(spi_pkg::REG_SEQ0 + i))
          seq_q[i] <= bus.wdata;
    end
  end

  assign mode_o      = acq_pkg::mode_e'(cr_q[2:0]);
  assign direct_o    = direct_q;
  assign precharge_o = precharge_q[acq_pkg::COUNT_W-1:0];
  assign aperture_o  = aperture_q[acq_pkg::COUNT_W-1:0];
  assign seq_n_o     = seq_n_q[acq_pkg::SEQ_N_W-1:0];

  always_comb
  begin
    for (int i = 0; i < acq_pkg::SEQ_ENTRIES; i++)
      seq_o[i] = acq_pkg::seq_entry_t'(seq_q[i][$bits(acq_pkg::seq_entry_t)-1:0]);
  end

  // status: running 23, seq_n 22:20, level 18:16, flags 11:8, magic 7:0
  assign status_w = {8'h00, running_i, seq_n_o, 1'b0, level_i,
                     4'h0, hw_flags_i, spi_pkg::STATUS_MAGIC};

  ////////////////////////////////////////
  // readback

  always_comb
  begin
    rd_word = '0;               // unknown address reads zero
    case (bus.addr)
      spi_pkg::REG_CR:        rd_word = cr_q;
      spi_pkg::REG_DIRECT:    rd_word = direct_q;
      spi_pkg::REG_STATUS:    rd_word = status_w;
      spi_pkg::REG_PRECHARGE: rd_word = precharge_q;
      spi_pkg::REG_APERTURE:  rd_word = aperture_q;
      spi_pkg::REG_SEQ_N:     rd_word = seq_n_q;
      spi_pkg::REG_RESULT:    rd_word = (level_i != '0) ? head_i : '0;   // empty reads 0
      default: ;
    endcase
    for (int i = 0; i < acq_pkg::SEQ_ENTRIES; i++)
      if (bus.addr == spi_pkg::reg_addr_e'(spi_pkg::REG_SEQ0 + i))
        rd_word = seq_q[i];
  end

  // captured on rd, head taken before the pop advances it
  always_ff @(posedge CLK)
  begin
    if (bus.rd)
      bus.rdata <= rd_word;
  end

  assign pop_o = bus.rd && (bus.addr == spi_pkg::REG_RESULT) && (level_i != '0);

endmodule

/* hw/result_fifo.sv */
/*
  result fifo, four records deep
  circular buffer between sequencer and register bank, returns a credit per pop
*/
`timescale 1ns/10ps

module result_fifo
(
  input  logic                        CLK,
  input  logic                        rst_i,
  input  logic                        push_i,       // only with a credit held
  input  acq_pkg::result_t            record_i,
  input  logic                        pop_i,
  output acq_pkg::result_t            head_o,       // valid while level nonzero
  output logic [acq_pkg::LEVEL_W-1:0] level_o,
  output logic                        credit_ret_o
);

  acq_pkg::result_t mem [acq_pkg::RESULT_DEPTH];
  logic [$clog2(acq_pkg::RESULT_DEPTH)-1:0] wr_ptr;
  logic [$clog2(acq_pkg::RESULT_DEPTH)-1:0] rd_ptr;
  logic do_pop;

  assign do_pop = pop_i && (level_o != '0);   // ignore pop on empty

  always_ff @(posedge CLK)
  begin
    if (push_i)
      mem[wr_ptr] <= record_i;
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge CLK)
  begin
    if (rst_i)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      level_o <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push_i, do_pop})
        2'b10:   level_o <= level_o + 1'b1;
        2'b01:   level_o <= level_o - 1'b1;
        default: ;        // push + pop keeps level
      endcase
    end
  end

  assign head_o       = mem[rd_ptr];
  assign credit_ret_o = do_pop;

endmodule

/* hw/seq_acq.sv */
/*
  sequence acquisition controller
  steps azmux / precharge switches through the sequence, times precharge and
  aperture with a mocked conversion, pushes one record per sample on credit
*/
`timescale 1ns/10ps

module seq_acq
(
  input  logic                          CLK,
  input  logic                          rst_i,
  input  logic                          trig_i,
  input  logic                          enable_i,     // mode is sequence
  input  logic [acq_pkg::COUNT_W-1:0]   precharge_i,
  input  logic [acq_pkg::COUNT_W-1:0]   aperture_i,
  input  logic [acq_pkg::SEQ_N_W-1:0]   seq_n_i,
  input  acq_pkg::seq_entry_t [acq_pkg::SEQ_ENTRIES-1:0] seq_i,
  input  logic                          credit_ret_i,
  output logic                          push_o,
  output acq_pkg::result_t              record_o,
  output logic [acq_pkg::AZMUX_W-1:0]   azmux_o,
  output logic [acq_pkg::PC_SW_W-1:0]   pc_sw_o,
  output logic                          running_o,
  output logic [3:0]                    leds_o,
  output logic [7:0]                    monitor_o
);

  acq_pkg::seq_state_e            state;
  acq_pkg::seq_entry_t            entry;        // current sequence entry
  logic [acq_pkg::COUNT_W-1:0]    cnt;          // phase cycles remaining - 1
  logic [acq_pkg::COUNT_W-1:0]    pre_load;
  logic [acq_pkg::COUNT_W-1:0]    ap_load;
  logic [acq_pkg::SEQ_N_W-1:0]    idx;
  logic [acq_pkg::SEQ_N_W-1:0]    last_idx;
  logic [acq_pkg::SERIAL_W-1:0]   serial;
  logic [acq_pkg::LEVEL_W-1:0]    credits;      // free fifo slots
  logic                           run;
  logic                           sample_done;

  assign run      = trig_i & enable_i;
  assign pre_load = (precharge_i == '0) ? '0 : precharge_i - 1'b1;   // 0 acts as 1
  assign ap_load  = (aperture_i == '0) ? '0 : aperture_i - 1'b1;
  assign last_idx = (seq_n_i == '0) ? '0 : seq_n_i - 1'b1;
  assign entry    = seq_i[idx[$clog2(acq_pkg::SEQ_ENTRIES)-1:0]];

  // aperture end with room, or credit back while waiting
  assign sample_done = run && (credits != '0) &&
                       ((state == acq_pkg::ST_APERTURE && cnt == '0) ||
                        state == acq_pkg::ST_WAIT_CREDIT);

  ////////////////////////////////////////
  // sample fsm, trigger low returns to idle

  always_ff @(posedge CLK)
  begin
    if (rst_i || !run)
    begin
      state  <= acq_pkg::ST_IDLE;
      cnt    <= '0;
      idx    <= '0;
      serial <= '0;
    end
    else
    begin
      case (state)
        acq_pkg::ST_IDLE:
        begin
          state <= acq_pkg::ST_PRECHARGE;
          cnt   <= pre_load;
        end
        acq_pkg::ST_PRECHARGE:
        begin
          if (cnt == '0)
          begin
            state <= acq_pkg::ST_APERTURE;
            cnt   <= ap_load;
          end
          else
            cnt <= cnt - 1'b1;
        end
        default:                // aperture or waiting on credit
        begin
          if (sample_done)
          begin
            state  <= acq_pkg::ST_PRECHARGE;
            cnt    <= pre_load;
            idx    <= (idx >= last_idx) ? '0 : idx + 1'b1;   // wrap
            serial <= serial + 1'b1;
          end
          else if (cnt == '0)
            state <= acq_pkg::ST_WAIT_CREDIT;   // hold switches
          else
            cnt <= cnt - 1'b1;
        end
      endcase
    end
  end

  // credits: one out per push, one back per fifo pop
  always_ff @(posedge CLK)
  begin
    if (rst_i)
      credits <= acq_pkg::RESULT_DEPTH[acq_pkg::LEVEL_W-1:0];
    else
    begin
      case ({push_o, credit_ret_i})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: ;
      endcase
    end
  end

  assign push_o              = sample_done;
  assign record_o.serial     = serial;
  assign record_o.azmux      = entry.azmux;
  assign record_o.first      = (idx == '0);
  assign record_o.sample_idx = idx;

  assign running_o = (state != acq_pkg::ST_IDLE);
  assign azmux_o   = running_o ? entry.azmux : '0;
  assign pc_sw_o   = (state == acq_pkg::ST_APERTURE || state == acq_pkg::ST_WAIT_CREDIT) ?
                     entry.pc_sw : '0;    // closed only in aperture
  assign leds_o    = {running_o, record_o.first, idx[1:0]};
  assign monitor_o = {3'b000, state, idx};

endmodule

/* hw/spi_bus_if.sv */
/*
  register access bus
  spi slave issues read / write strobes, register bank returns read data
*/
`timescale 1ns/10ps

interface spi_bus_if;

  logic                      wr;      // pulse, addr + wdata valid
  logic                      rd;      // pulse after the command byte
  spi_pkg::reg_addr_e        addr;
  logic [acq_pkg::REG_W-1:0] wdata;
  logic [acq_pkg::REG_W-1:0] rdata;   // valid the cycle after rd

  modport slave
  (
    output wr, rd, addr, wdata,
    input  rdata
  );

  modport bank
  (
    input  wr, rd, addr, wdata,
    output rdata
  );

endinterface

/* hw/spi_pkg.sv */
/*
  spi definitions
  frame widths, chip-select codes, register map and status magic
*/
package spi_pkg;

  localparam int CMD_W   = 8;                       // write bit + 7 bit address
  localparam int FRAME_W = CMD_W + acq_pkg::REG_W;  // command then data word

  localparam logic [7:0] STATUS_MAGIC = 8'hAA;

  // chip-select vector codes
  typedef enum logic [2:0] {
    CS_DEASSERT   = 3'd0,
    CS_FPGA       = 3'd1,     // register bank in the fpga
    CS_4094       = 3'd2,
    CS_INVERT_DAC = 3'd3,
    CS_MDAC       = 3'd4
  } cs_vec_e;

  // register map
  typedef enum logic [6:0] {
    REG_CR        = 7'h01,    // mode in bits 2:0
    REG_DIRECT    = 7'h02,
    REG_STATUS    = 7'h03,    // read only
    REG_PRECHARGE = 7'h04,
    REG_APERTURE  = 7'h05,
    REG_SEQ_N     = 7'h06,
    REG_SEQ0      = 7'h07,
    REG_SEQ1      = 7'h08,
    REG_SEQ2      = 7'h09,
    REG_SEQ3      = 7'h0A,
    REG_RESULT    = 7'h0B     // read pops the fifo head
  } reg_addr_e;

endpackage

/* hw/spi_slave.sv */
/*
  spi mode 0 slave, oversampled on CLK
  8 bit command (write flag + address) then 32 bit data, msb first
*/
`timescale 1ns/10ps

module spi_slave
(
  input  logic     CLK,
  input  logic     rst_i,
  input  logic     sck_i,
  input  logic     sdi_i,
  input  logic     cs_i,      // high while the fpga is selected
  output logic     sdo_o,
  spi_bus_if.slave bus
);

  logic [1:0] sck_sync;
  logic [1:0] sdi_sync;
  logic       sck_d;          // previous synced sck
  logic       sck_rise;
  logic       sck_fall;
  logic [$clog2(spi_pkg::FRAME_W+1)-1:0] bit_cnt;   // bits received in frame
  logic [spi_pkg::CMD_W-2:0] cmd_sr;                // first 7 command bits
  logic [acq_pkg::REG_W-1:0] tx_sr;                 // read word, shifted out
  logic       is_write;
  logic       rd_q;           // rdata lands this cycle

  ////////////////////////////////////////
  // synchronizers and edge detect

  always_ff @(posedge CLK)
  begin
    if (rst_i)
    begin
      sck_sync <= '0;
      sdi_sync <= '0;
      sck_d    <= 1'b0;
    end
    else
    begin
      sck_sync <= {sck_sync[0], sck_i};
      sdi_sync <= {sdi_sync[0], sdi_i};
      sck_d    <= sck_sync[1];
    end
  end

  assign sck_rise = sck_sync[1] & ~sck_d;
  assign sck_fall = ~sck_sync[1] & sck_d;

  ////////////////////////////////////////
  // frame control, cleared while deselected

  always_ff @(posedge CLK)
  begin
    if (rst_i || !cs_i)
    begin
      bit_cnt  <= '0;       // partial frame aborted
      is_write <= 1'b0;
      bus.rd   <= 1'b0;
      bus.wr   <= 1'b0;
      rd_q     <= 1'b0;
      tx_sr    <= '0;
      sdo_o    <= 1'b0;
    end
    else
    begin
      bus.rd <= 1'b0;
      bus.wr <= 1'b0;
      rd_q   <= bus.rd;
      if (rd_q)
        tx_sr <= bus.rdata;                     // load read word
      if (sck_rise && bit_cnt < spi_pkg::FRAME_W)
      begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == spi_pkg::CMD_W - 1)      // last command bit
        begin
          is_write <= cmd_sr[spi_pkg::CMD_W-2];
          bus.rd   <= ~cmd_sr[spi_pkg::CMD_W-2];
        end
        if (bit_cnt == spi_pkg::FRAME_W - 1)    // last data bit
          bus.wr <= is_write;
      end
      // miso changes on falling sck during the data phase only
      if (sck_fall && bit_cnt >= spi_pkg::CMD_W)
      begin
        if (bit_cnt < spi_pkg::FRAME_W)
        begin
          sdo_o <= tx_sr[acq_pkg::REG_W-1];
          tx_sr <= {tx_sr[acq_pkg::REG_W-2:0], 1'b0};
        end
        else
          sdo_o <= 1'b0;    // frame complete
      end
    end
  end

  // command / data shifting, sampled on rising sck
  always_ff @(posedge CLK)
  begin
    if (sck_rise && cs_i)
    begin
      if (bit_cnt < spi_pkg::CMD_W - 1)
        cmd_sr <= {cmd_sr[spi_pkg::CMD_W-3:0], sdi_sync[1]};
      else if (bit_cnt == spi_pkg::CMD_W - 1)
        bus.addr <= spi_pkg::reg_addr_e'({cmd_sr[spi_pkg::CMD_W-3:0], sdi_sync[1]});
      else if (bit_cnt < spi_pkg::FRAME_W)
        bus.wdata <= {bus.wdata[acq_pkg::REG_W-2:0], sdi_sync[1]};  // full at wr
    end
  end

endmodule

/* tests/tb_dmm_top.sv */
/*
  testbench for the bench-meter control core
  bit-banged spi host, directed tests for direct mode, chip-select decode,
  status word, sequence acquisition, back-pressure and drain
*/
`timescale 1ns/10ps

module tb_dmm_top;

  // about 37 spi frames of 340 cycles plus acquisition waits, twice over
  localparam int TIMEOUT_CYCLES = 30000;
  localparam int WAIT_LIMIT     = 2000;   // cycles to wait for a result

  logic       CLK;
  logic       rst_i;
  logic       SCK;
  logic       SDI;
  logic       SDO;
  logic [2:0] spi_cs_vec_i;
  logic       spi_glb_clk_o;
  logic       spi_glb_mosi_o;
  logic       spi_4094_strobe_o;
  logic       spi_invert_dac_ss_o;
  logic       spi_iso_cs_o;
  logic [3:0] hw_flags_i;
  logic       sa_trig_i;
  logic [3:0] leds_o;
  logic [7:0] monitor_o;
  logic [1:0] pc_sw_o;
  logic [3:0] azmux_o;
  logic       spi_interrupt_o;

  integer     seed = 32'had856bfd;
  int         cycle_cnt;
  int         test_errors;
  int         tests_passed;
  int         tests_failed;
  int         next_serial;          // serial expected from the next pop
  logic [5:0] entry_tab [0:2];      // sequence entries with pc_sw in 5:4 and azmux in 3:0

  dmm_top u_dmm_top
  (
    .CLK(CLK), .rst_i(rst_i), .SCK(SCK), .SDI(SDI), .SDO(SDO),
    .spi_cs_vec_i(spi_cs_vec_i), .spi_glb_clk_o(spi_glb_clk_o),
    .spi_glb_mosi_o(spi_glb_mosi_o), .spi_4094_strobe_o(spi_4094_strobe_o),
    .spi_invert_dac_ss_o(spi_invert_dac_ss_o), .spi_iso_cs_o(spi_iso_cs_o),
    .hw_flags_i(hw_flags_i), .sa_trig_i(sa_trig_i), .leds_o(leds_o),
    .monitor_o(monitor_o), .pc_sw_o(pc_sw_o), .azmux_o(azmux_o),
    .spi_interrupt_o(spi_interrupt_o)
  );

  initial CLK = 1'b0;
  always #4 CLK = ~CLK;           // 8 ns period

  ////////////////////////////////////////
  // run limit

  always @(posedge CLK)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("run stopped, cycle limit of %0d reached", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // check helpers

  task automatic expect_equal(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic expect_true(input logic cond, input string msg);
    assert (cond === 1'b1)
    else
    begin
      $display("%s", msg);
      test_errors++;
    end
  endtask

  task automatic start_test;
    test_errors = 0;
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0)
    begin
      $display("PASS %s", name);
      tests_passed++;
    end
    else
    begin
      $display("FAIL %s, %0d errors", name, test_errors);
      tests_failed++;
    end
  endtask

  ////////////////////////////////////////
  // mode 0 spi host with sck half period of 4 clk cycles

  task automatic spi_frame(input logic wr, input logic [6:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    logic [39:0] tx;
    tx    = {wr, addr, wdata};
    rdata = '0;
    @(negedge CLK);
    spi_cs_vec_i = spi_pkg::CS_FPGA;
    SCK          = 1'b0;
    repeat (4) @(negedge CLK);
    for (int i = 39; i >= 0; i--)
    begin
      SDI = tx[i];                  // host changes mosi with sck low
      repeat (4) @(negedge CLK);
      if (i < 32)
        rdata[i] = SDO;             // sampled at the rising sck
      SCK = 1'b1;
      repeat (4) @(negedge CLK);
      SCK = 1'b0;
    end
    repeat (4) @(negedge CLK);
    spi_cs_vec_i = spi_pkg::CS_DEASSERT;
    SDI          = 1'b0;
    repeat (8) @(negedge CLK);      // write settles
  endtask

  task automatic spi_write(input logic [6:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    spi_frame(1'b1, addr, data, unused);
  endtask

  task automatic spi_read(input logic [6:0] addr, output logic [31:0] data);
    spi_frame(1'b0, addr, 32'h0, data);
  endtask

  // wait for the result interrupt, then pop one record
  task automatic pop_result(output logic [31:0] data);
    int waited;
    waited = 0;
    while (!spi_interrupt_o && waited < WAIT_LIMIT)
    begin
      @(negedge CLK);
      waited++;
    end
    expect_true(spi_interrupt_o, "no result became ready in time");
    spi_read(spi_pkg::REG_RESULT, data);
  endtask

  // record holds serial 24, azmux 4, first 1 and index 3 bits from the msb
  task automatic verify_record(input logic [31:0] w, input int serial);
    int idx;
    idx = serial % 3;
    expect_equal("record.serial", serial, w[31:8]);
    expect_equal("record.azmux", entry_tab[idx][3:0], w[7:4]);
    expect_equal("record.first", idx == 0, w[3]);
    expect_equal("record.sample_idx", idx, w[2:0]);
  endtask

  ////////////////////////////////////////
  // directed tests

  task automatic reset_direct_test;
    logic [31:0] w;
    logic [31:0] rd;
    start_test();
    expect_equal("leds_o", 0, leds_o);
    expect_equal("monitor_o", 0, monitor_o);
    expect_equal("pc_sw_o", 0, pc_sw_o);
    expect_equal("azmux_o", 0, azmux_o);
    expect_equal("spi_interrupt_o", 0, spi_interrupt_o);
    expect_equal("SDO", 0, SDO);
    w = $random(seed);
    spi_write(spi_pkg::REG_DIRECT, w);
    spi_read(spi_pkg::REG_DIRECT, rd);
    expect_equal("REG_DIRECT", w, rd);
    spi_write(spi_pkg::REG_PRECHARGE, 32'h0012_3456);
    spi_read(spi_pkg::REG_PRECHARGE, rd);
    expect_equal("REG_PRECHARGE", 32'h0012_3456, rd);
    @(negedge CLK);
    expect_equal("leds_o", w[3:0], leds_o);
    expect_equal("monitor_o", w[11:4], monitor_o);
    expect_equal("pc_sw_o", w[13:12], pc_sw_o);
    expect_equal("azmux_o", w[17:14], azmux_o);
    expect_equal("spi_interrupt_o", w[18], spi_interrupt_o);
    end_test("reset_direct");
  endtask

  task automatic cs_decode_test;
    start_test();
    for (int c = 0; c < 8; c++)
    begin
      @(negedge CLK);
      spi_cs_vec_i = c[2:0];
      SCK          = 1'b1;
      SDI          = 1'b0;
      @(posedge CLK);
      expect_equal("spi_4094_strobe_o", c == 2, spi_4094_strobe_o);
      expect_equal("spi_invert_dac_ss_o", c != 3, spi_invert_dac_ss_o);
      expect_equal("spi_iso_cs_o", c != 4, spi_iso_cs_o);
      expect_equal("spi_glb_clk_o", 1, spi_glb_clk_o);
      expect_equal("spi_glb_mosi_o", c == 1, spi_glb_mosi_o);   // parked for fpga
      @(negedge CLK);
      SCK = 1'b0;
      SDI = 1'b1;
      @(posedge CLK);
      expect_equal("spi_glb_clk_o", c == 1, spi_glb_clk_o);
      expect_equal("spi_glb_mosi_o", 1, spi_glb_mosi_o);
    end
    @(negedge CLK);
    spi_cs_vec_i = spi_pkg::CS_DEASSERT;
    SDI          = 1'b0;
    repeat (8) @(negedge CLK);    // slave frame cleared
    end_test("cs_decode");
  endtask

  task automatic status_test;
    logic [3:0]  flags;
    logic [31:0] rd;
    start_test();
    @(negedge CLK);
    flags      = 4'($random(seed));
    hw_flags_i = flags;
    spi_write(spi_pkg::REG_SEQ_N, 32'd5);
    spi_read(spi_pkg::REG_STATUS, rd);
    expect_equal("REG_STATUS", 32'hAA | (flags << 8) | (32'd5 << 20), rd);
    end_test("status");
  endtask

  task automatic seq_acq_test;
    logic [31:0] rd;
    start_test();
    entry_tab[0] = 6'h13;
    entry_tab[1] = 6'h25;
    entry_tab[2] = 6'h3A;
    spi_write(spi_pkg::REG_SEQ_N, 32'd3);
    for (int i = 0; i < 3; i++)
      spi_write(7'(spi_pkg::REG_SEQ0 + i), {26'h0, entry_tab[i]});
    spi_write(spi_pkg::REG_PRECHARGE, 32'd5);
    spi_write(spi_pkg::REG_APERTURE, 32'd10);
    spi_write(spi_pkg::REG_CR, {29'h0, acq_pkg::MODE_SEQ});
    @(negedge CLK);
    sa_trig_i   = 1'b1;
    next_serial = 0;
    for (int n = 0; n < 6; n++)
    begin
      pop_result(rd);
      verify_record(rd, next_serial);
      next_serial++;
    end
    end_test("seq_acq");
  endtask

  task automatic back_pressure_test;
    logic [31:0] rd;
    int          stall_idx;
    start_test();
    repeat (1000) @(negedge CLK);   // fifo fills with no reads
    // held on the sample after the four queued records
    stall_idx = (next_serial + 4) % 3;
    expect_equal("azmux_o", entry_tab[stall_idx][3:0], azmux_o);
    expect_equal("pc_sw_o", entry_tab[stall_idx][5:4], pc_sw_o);
    spi_read(spi_pkg::REG_STATUS, rd);
    expect_equal("status.level", 4, rd[18:16]);
    expect_equal("status.running", 1, rd[23]);
    expect_equal("spi_interrupt_o", 1, spi_interrupt_o);
    for (int n = 0; n < 10; n++)
    begin
      pop_result(rd);
      verify_record(rd, next_serial);
      next_serial++;
    end
    end_test("back_pressure");
  endtask

  task automatic stop_drain_test;
    logic [31:0] rd;
    int          drained;
    logic        empty;
    start_test();
    @(negedge CLK);
    sa_trig_i = 1'b0;
    repeat (4) @(negedge CLK);
    drained = 0;
    empty   = 1'b0;
    while (!empty && drained < 8)
    begin
      spi_read(spi_pkg::REG_RESULT, rd);
      if (rd == 32'h0)
        empty = 1'b1;
      else
      begin
        verify_record(rd, next_serial);
        next_serial++;
        drained++;
      end
    end
    expect_equal("drained records", 4, drained);
    spi_read(spi_pkg::REG_STATUS, rd);
    expect_equal("status.running", 0, rd[23]);
    expect_equal("status.level", 0, rd[18:16]);
    spi_read(spi_pkg::REG_RESULT, rd);
    expect_equal("REG_RESULT", 0, rd);
    expect_equal("spi_interrupt_o", 0, spi_interrupt_o);
    end_test("stop_drain");
  endtask

  ////////////////////////////////////////
  // main sequence

  initial
  begin
    cycle_cnt    = 0;
    tests_passed = 0;
    tests_failed = 0;
    next_serial  = 0;
    rst_i        = 1'b1;
    SCK          = 1'b0;
    SDI          = 1'b0;
    spi_cs_vec_i = spi_pkg::CS_DEASSERT;
    hw_flags_i   = 4'h0;
    sa_trig_i    = 1'b0;
    repeat (3) @(negedge CLK);
    rst_i = 1'b0;
    @(negedge CLK);

    reset_direct_test();
    cs_decode_test();
    status_test();
    seq_acq_test();
    back_pressure_test();
    stop_drain_test();

    $display("tests passed %0d failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
